// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the echo unit testbench with Verilator.
# The result comes from the simulation log.

set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_echo_delay -f tb.f > "$BUILD_LOG" 2>&1 \
  || { cat "$BUILD_LOG"; echo "build failed"; exit 1; }

./obj_dir/Vtb_echo_delay > "$SIM_LOG" 2>&1 \
  || echo "simulator returned an error status"

cat "$SIM_LOG"

grep -qx "TB PASSED" "$SIM_LOG" \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }

// ==== tb.f ====
+incdir+verilog
verilog/echo_pkg.sv
verilog/sram_if.sv
verilog/frame_sequencer.sv
verilog/halfword_sram.sv
verilog/echo_mixer.sv
verilog/echo_delay_top.sv
test/tb_clock_gen.sv
test/tb_echo_delay.sv

// ==== test/tb_clock_gen.sv ====
// Free-running testbench clock, starts low at time zero.

`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;  // half period per toggle

endmodule

// ==== test/tb_echo_delay.sv ====
// Random and directed frames against a delay-line model of the echo unit.
// Inputs change on the falling edge, outputs are sampled there too.
// The model pointer assumes DELAY_SAMPLES is a power of two.

`timescale 1ns/1ns

`include "echo_params.svh"

module tb_echo_delay
  import echo_pkg::*;
();

  localparam int PTR_W       = $clog2(`DELAY_SAMPLES);
  localparam int LATENCY     = 6;   // falling edges from trigger drive to out_valid
  localparam int VALID_WAIT  = 12;
  localparam int T2_FRAMES   = `DELAY_SAMPLES;
  localparam int T3_FRAMES   = 3 * `DELAY_SAMPLES;
  localparam int T4_FRAMES   = 2 * `DELAY_SAMPLES;
  localparam int T5_TRIGGERS = 3;
  localparam int T6_FRAMES   = `DELAY_SAMPLES;
  localparam int CYCLE_LIMIT =
    (T2_FRAMES + T3_FRAMES + T4_FRAMES + T5_TRIGGERS + T6_FRAMES) * 24 + 200;

  logic                 clk;
  logic                 n_rst;
  logic                 trigger;
  logic                 mem_clr;
  logic [`SAMPLE_W-1:0] sample_in;
  logic [`SAMPLE_W-1:0] sample_out;
  logic                 out_valid;

  seq_state_t seq_state;  // for messages only

  // reference delay line
  logic [`SAMPLE_W-1:0] hist [`DELAY_SAMPLES];
  logic [PTR_W-1:0]     model_ptr;

  int errors       = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycle_count  = 0;

  tb_clock_gen #(.PERIOD_NS(40)) u_clk (.clk(clk));

  echo_delay_top u_dut (
    .clk        (clk),
    .n_rst      (n_rst),
    .trigger    (trigger),
    .mem_clr    (mem_clr),
    .sample_in  (sample_in),
    .sample_out (sample_out),
    .out_valid  (out_valid)
  );

  assign seq_state = u_dut.u_seq.state;

  // watchdog
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the run did not complete", cycle_count);
      $display("TB FAILED");
      $finish;
    end
  end

  // one channel: dry plus halved wet, clamped to 16-bit signed
  function automatic logic [`HALF_W-1:0] mix_channel(input logic [`HALF_W-1:0] dry,
                                                     input logic [`HALF_W-1:0] wet);
    int d;
    int w;
    int s;
    d = int'($signed(dry));
    w = int'($signed(wet));
    s = d + (w >>> `ECHO_SHIFT);
    if (s > 32767)
      s = 32767;
    else if (s < -32768)
      s = -32768;
    return s[`HALF_W-1:0];
  endfunction

  // advance the model by one frame, returns the expected output
  function automatic logic [`SAMPLE_W-1:0] model_frame(input logic [`SAMPLE_W-1:0] dry);
    logic [`SAMPLE_W-1:0] wet;
    wet = hist[model_ptr];
    hist[model_ptr] = dry;
    if (model_ptr == PTR_W'(`DELAY_SAMPLES - 1))
      model_ptr = '0;
    else
      model_ptr = model_ptr + 1'b1;
    return {mix_channel(dry[`SAMPLE_W-1:`HALF_W], wet[`SAMPLE_W-1:`HALF_W]),
            mix_channel(dry[`HALF_W-1:0], wet[`HALF_W-1:0])};
  endfunction

  task automatic model_clear();
    hist = '{default: '0};
    model_ptr = '0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      assert (!out_valid) else begin
        $display("unexpected out_valid with no frame in progress at time %0t", $time);
        errors++;
      end
    end
  endtask

  // one frame; retrigger pulses trigger again 2 cycles in
  task automatic run_frame(input logic [`SAMPLE_W-1:0] dry, input bit retrigger,
                           output logic [`SAMPLE_W-1:0] got);
    logic [`SAMPLE_W-1:0] expected;
    int waited;
    expected  = model_frame(dry);
    sample_in = dry;
    trigger   = 1'b1;
    waited    = 0;
    do begin
      @(negedge clk);
      waited++;
      trigger = (retrigger && waited == 2);
      if (trigger)
        sample_in = $urandom();  // must not be taken
    end while (!out_valid && waited < VALID_WAIT);
    trigger = 1'b0;
    got = sample_out;
    assert (out_valid) else begin
      $display("no out_valid within %0d cycles of the trigger, sequencer in %s",
               VALID_WAIT, seq_state.name());
      errors++;
    end
    if (out_valid) begin
      assert (waited == LATENCY) else begin
        $display("FAIL %0t: out_valid latency expected %0d got %0d", $time, LATENCY, waited);
        errors++;
      end
      assert (sample_out === expected) else begin
        $display("FAIL %0t: sample_out expected %h got %h (dry %h)",
                 $time, expected, sample_out, dry);
        errors++;
      end
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
      tests_failed++;
    end
  endtask

  initial begin
    logic [`SAMPLE_W-1:0] dry;
    logic [`SAMPLE_W-1:0] got;
    int mark;

    void'($urandom(31));
    n_rst     = 1'b0;
    trigger   = 1'b0;
    mem_clr   = 1'b0;
    sample_in = '0;
    model_clear();

    repeat (4) @(negedge clk);
    n_rst = 1'b1;

    // 1: quiet after reset
    mark = errors;
    repeat (10) begin
      @(negedge clk);
      assert (!out_valid && sample_out === '0) else begin
        $display("FAIL %0t: after reset expected out_valid 0, sample_out 0, got %b, %h",
                 $time, out_valid, sample_out);
        errors++;
      end
    end
    report_test("reset_quiet", mark);

    // 2: empty history, output is the dry sample
    mark = errors;
    for (int i = 0; i < T2_FRAMES; i++) begin
      dry = $urandom();
      run_frame(dry, 1'b0, got);
      assert (got === dry) else begin
        $display("FAIL %0t: empty history expected %h got %h", $time, dry, got);
        errors++;
      end
      idle_cycles($urandom_range(14, 2));
    end
    report_test("first_frames_dry", mark);

    // 3: random frames with echo
    mark = errors;
    for (int i = 0; i < T3_FRAMES; i++) begin
      run_frame($urandom(), 1'b0, got);
      idle_cycles($urandom_range(14, 2));
    end
    report_test("random_mix", mark);

    // 4: left full positive, right full negative; second pass must clamp
    mark = errors;
    for (int i = 0; i < T4_FRAMES; i++) begin
      run_frame(32'h7fff_8000, 1'b0, got);
      if (i >= `DELAY_SAMPLES) begin
        assert (got === 32'h7fff_8000) else begin
          $display("FAIL %0t: saturation expected 7fff8000 got %h", $time, got);
          errors++;
        end
      end
      idle_cycles($urandom_range(14, 2));
    end
    report_test("saturation", mark);

    // 5: second trigger inside a frame is dropped
    mark = errors;
    run_frame($urandom(), 1'b1, got);
    idle_cycles(14);  // a taken retrigger would show up here
    run_frame($urandom(), 1'b0, got);
    idle_cycles(4);
    report_test("busy_trigger", mark);

    // 6: clear between frames, history starts over
    mark = errors;
    mem_clr = 1'b1;
    @(negedge clk);
    mem_clr = 1'b0;
    model_clear();
    idle_cycles(2);
    for (int i = 0; i < T6_FRAMES; i++) begin
      dry = $urandom();
      run_frame(dry, 1'b0, got);
      assert (got === dry) else begin
        $display("FAIL %0t: after clear expected %h got %h", $time, dry, got);
        errors++;
      end
      idle_cycles($urandom_range(14, 2));
    end
    report_test("mem_clear", mark);

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/echo_delay_top.sv ====
// Stereo echo unit top level.
// No back-pressure; out_valid follows an accepted trigger by 6 cycles.

`timescale 1ns/1ns

`include "echo_params.svh"

module echo_delay_top (
  input  logic                 clk,
  input  logic                 n_rst,
  input  logic                 trigger,
  input  logic                 mem_clr,
  input  logic [`SAMPLE_W-1:0] sample_in,
  output logic [`SAMPLE_W-1:0] sample_out,
  output logic                 out_valid
);

  logic [`SAMPLE_W-1:0] dry_sample;
  logic [`SAMPLE_W-1:0] delayed_sample;
  logic                 frame_done;

  sram_if u_mem_if ();

  frame_sequencer u_seq (
    .clk            (clk),
    .n_rst          (n_rst),
    .trigger        (trigger),
    .mem_clr        (mem_clr),
    .sample_in      (sample_in),
    .mem            (u_mem_if.master),
    .dry_sample     (dry_sample),
    .delayed_sample (delayed_sample),
    .frame_done     (frame_done)
  );

  // delay line storage
  halfword_sram u_sram (
    .clk     (clk),
    .n_rst   (n_rst),
    .mem_clr (mem_clr),
    .mem     (u_mem_if.slave)
  );

  echo_mixer u_mixer (
    .clk            (clk),
    .n_rst          (n_rst),
    .dry_sample     (dry_sample),
    .delayed_sample (delayed_sample),
    .frame_done     (frame_done),
    .sample_out     (sample_out),
    .out_valid      (out_valid)
  );

endmodule

// ==== verilog/echo_mixer.sv ====
// Per-channel mix: dry + (delayed >>> ECHO_SHIFT), clamped to signed 16 bits.
// Output registers on frame_done and holds between frames.

`timescale 1ns/1ns

`include "echo_params.svh"

module echo_mixer
  import echo_pkg::*;
(
  input  logic                 clk,
  input  logic                 n_rst,
  input  logic [`SAMPLE_W-1:0] dry_sample,
  input  logic [`SAMPLE_W-1:0] delayed_sample,
  input  logic                 frame_done,
  output logic [`SAMPLE_W-1:0] sample_out,
  output logic                 out_valid
);

  half_t dry_l;
  half_t dry_r;
  half_t wet_l;
  half_t wet_r;
  half_t mix_l;
  half_t mix_r;

  // saturating add of one channel, one guard bit
  function automatic half_t sat_mix(input half_t dry, input half_t wet);
    logic signed [`HALF_W:0] sum;
    sum = dry + (wet >>> `ECHO_SHIFT);
    if (sum[`HALF_W] != sum[`HALF_W-1]) begin
      // overflow, sign bit tells the direction
      if (sum[`HALF_W])
        return {1'b1, {(`HALF_W-1){1'b0}}};
      else
        return {1'b0, {(`HALF_W-1){1'b1}}};
    end
    return sum[`HALF_W-1:0];
  endfunction

  assign dry_l = dry_sample[`SAMPLE_W-1:`HALF_W];
  assign dry_r = dry_sample[`HALF_W-1:0];
  assign wet_l = delayed_sample[`SAMPLE_W-1:`HALF_W];
  assign wet_r = delayed_sample[`HALF_W-1:0];

  assign mix_l = sat_mix(dry_l, wet_l);
  assign mix_r = sat_mix(dry_r, wet_r);

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      sample_out <= '0;
      out_valid  <= 1'b0;
    end else begin
      out_valid <= frame_done;  // one cycle per frame
      if (frame_done)
        sample_out <= {mix_l, mix_r};
    end
  end

endmodule

// ==== verilog/echo_params.svh ====
// Shared sizing for the echo unit.
// ADDR_W must cover 2*DELAY_SAMPLES halfword locations.
// DELAY_SAMPLES must be a power of two no larger than 2**(ADDR_W-1).

`ifndef ECHO_PARAMS_SVH
`define ECHO_PARAMS_SVH

// delay depth in frames, small for simulation
`define DELAY_SAMPLES 16

`define HALF_W 16    // one channel
`define SAMPLE_W 32  // left in upper half, right in lower half

// halfword address, two words per stored frame
`define ADDR_W 5

// delayed sample is scaled by 2**-ECHO_SHIFT before mixing
`define ECHO_SHIFT 1

`endif

// ==== verilog/echo_pkg.sv ====
// Types shared by the echo unit and its testbench.
// half_t width follows HALF_W from the params header.

`include "echo_params.svh"

package echo_pkg;

  // frame sequencer states, one read-before-write frame
  typedef enum logic [2:0] {
    idle,
    read_hi,   // read even word of the slot
    read_lo,   // read odd word, capture high half
    write_hi,  // write dry high half, capture low half
    write_lo,  // write dry low half
    done       // frame_done pulse, pointer advance
  } seq_state_t;

  // one signed audio channel
  typedef logic signed [`HALF_W-1:0] half_t;

endpackage

// ==== verilog/frame_sequencer.sv ====
// One frame per accepted trigger: two halfword reads, then two writes, same slot.
// Triggers outside idle are dropped. mem_clr abandons a frame with no frame_done.
// Slot pointer wraps at DELAY_SAMPLES, so the echo is exactly DELAY_SAMPLES frames old.

`timescale 1ns/1ns

`include "echo_params.svh"

module frame_sequencer
  import echo_pkg::*;
(
  input  logic                 clk,
  input  logic                 n_rst,
  input  logic                 trigger,
  input  logic                 mem_clr,
  input  logic [`SAMPLE_W-1:0] sample_in,
  sram_if.master               mem,
  output logic [`SAMPLE_W-1:0] dry_sample,
  output logic [`SAMPLE_W-1:0] delayed_sample,
  output logic                 frame_done
);

  localparam int SLOT_W = `ADDR_W - 1;
  localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`DELAY_SAMPLES - 1);

  seq_state_t state;
  seq_state_t next_state;

  logic [SLOT_W-1:0] slot;  // current frame slot in the delay line
  logic              accept;

  assign accept = (state == idle) && trigger && !mem_clr;

  // state and pointer
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      state <= idle;
      slot  <= '0;
    end else if (mem_clr) begin
      state <= idle;
      slot  <= '0;
    end else begin
      state <= next_state;
      if (state == done) begin
        if (slot == LAST_SLOT)
          slot <= '0;
        else
          slot <= slot + 1'b1;
      end
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      idle:     if (trigger) next_state = read_hi;
      read_hi:  next_state = read_lo;
      read_lo:  next_state = write_hi;
      write_hi: next_state = write_lo;
      write_lo: next_state = done;
      done:     next_state = idle;
      default:  next_state = idle;
    endcase
  end

  // payload: dry latch on accept, read-back assembled over two cycles
  always_ff @(posedge clk) begin
    if (accept)
      dry_sample <= sample_in;
    if (state == read_lo)
      delayed_sample[`SAMPLE_W-1:`HALF_W] <= mem.rdata;  // from read_hi
    if (state == write_hi)
      delayed_sample[`HALF_W-1:0] <= mem.rdata;          // from read_lo
  end

  // memory port, decoded from state
  always_comb begin
    mem.rd_en = 1'b0;
    mem.wr_en = 1'b0;
    mem.addr  = {slot, 1'b0};
    mem.wdata = '0;
    case (state)
      read_hi: begin
        mem.rd_en = 1'b1;
      end
      read_lo: begin
        mem.rd_en = 1'b1;
        mem.addr  = {slot, 1'b1};
      end
      write_hi: begin
        mem.wr_en = 1'b1;
        mem.wdata = half_t'(dry_sample[`SAMPLE_W-1:`HALF_W]);
      end
      write_lo: begin
        mem.wr_en = 1'b1;
        mem.addr  = {slot, 1'b1};
        mem.wdata = half_t'(dry_sample[`HALF_W-1:0]);
      end
      default: begin
        mem.rd_en = 1'b0;  // idle and done leave the port quiet
      end
    endcase
  end

  assign frame_done = (state == done);

endmodule

// ==== verilog/halfword_sram.sv ====
// Register-array halfword memory, 2*DELAY_SAMPLES words.
// Synchronous read and write; mem_clr zeroes every word and rdata in one edge.

`timescale 1ns/1ns

`include "echo_params.svh"

module halfword_sram
  import echo_pkg::*;
(
  input  logic   clk,
  input  logic   n_rst,
  input  logic   mem_clr,
  sram_if.slave  mem
);

  localparam int DEPTH = 2 * `DELAY_SAMPLES;

  half_t words [DEPTH];

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      for (int i = 0; i < DEPTH; i++)
        words[i] <= '0;
      mem.rdata <= '0;
    end else if (mem_clr) begin
      // whole buffer cleared at once
      for (int i = 0; i < DEPTH; i++)
        words[i] <= '0;
      mem.rdata <= '0;
    end else begin
      if (mem.wr_en)
        words[mem.addr] <= mem.wdata;
      if (mem.rd_en)
        mem.rdata <= words[mem.addr];  // held until next read
    end
  end

endmodule

// ==== verilog/sram_if.sv ====
// Halfword memory port between sequencer and buffer.
// rd_en and wr_en are never high together; rdata is valid one edge after rd_en.

`timescale 1ns/1ns

`include "echo_params.svh"

interface sram_if
  import echo_pkg::*;
();

  logic [`ADDR_W-1:0] addr;
  logic               rd_en;
  logic               wr_en;
  half_t              wdata;
  half_t              rdata;  // registered in the memory

  modport master (
    output addr, rd_en, wr_en, wdata,
    input  rdata
  );

  modport slave (
    input  addr, rd_en, wr_en, wdata,
    output rdata
  );

endinterface
